// File: project.f
source/evrPkg.sv
source/evrRegisterBank.sv
source/eventMappingRam.sv
source/triggerChannel.sv
source/eventTimeFifo.sv
source/eventReceiverTop.sv
test/eventReceiverTb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the event receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module eventReceiverTb -f project.f -o eventReceiverSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/eventReceiverSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: test/eventReceiverTb.sv
module eventReceiverTb import evrPkg::*; ();

    // longest run stays well under 1000 cycles so this limit leaves margin
    localparam int MaxCycles = 3000;
    localparam logic [15:0] IdleWord = 16'h00BC;
    localparam timeStamp_t TimeBase = 64'h0123_4567_FFFF_FF00;

    logic mgt_rec_clk = 1'b0;
    logic bus_reset_n;
    busAddr_t busAddr;
    busWord_t busWrData;
    logic busWrEn;
    logic busRdEn;
    busWord_t busRdData;
    logic busRdAck;
    logic [15:0] mgtParData;
    logic [1:0] mgtCharIsK;
    // free running counter as the external time
    timeStamp_t timeStamp = TimeBase;
    triggerVec_t trigger;
    logic intrFifoNotEmpty;
    logic intrFifoFull;

    int seed = 32'hb0c6102b;
    int cycleCount = 0;
    // idle level of all trigger outputs
    triggerVec_t polVec;
    timeStamp_t expTimes[$];
    eventCode_t expCodes[$];

    always #5 mgt_rec_clk = ~mgt_rec_clk;

    always @(posedge mgt_rec_clk) begin
        timeStamp <= timeStamp + 64'd1;
    end

    eventReceiverTop u_eventReceiverTop (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n),
        .busAddr(busAddr),
        .busWrData(busWrData),
        .busWrEn(busWrEn),
        .busRdEn(busRdEn),
        .busRdData(busRdData),
        .busRdAck(busRdAck),
        .mgtParData(mgtParData),
        .mgtCharIsK(mgtCharIsK),
        .timeStamp(timeStamp),
        .trigger(trigger),
        .intrFifoNotEmpty(intrFifoNotEmpty),
        .intrFifoFull(intrFifoFull)
    );

    always @(posedge mgt_rec_clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: run went past %0d cycles", MaxCycles);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic checkWord(input string name, input busWord_t got, input busWord_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkTriggers(input string name, input triggerVec_t got,
                                 input triggerVec_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // bus and link drivers
    //////////////////////////////////////////////////
    function automatic busAddr_t addrOf(input logic [1:0] bank, input eventCode_t index);
        busAddr_t addr;
        addr = '0;
        addr[BankMsb:BankLsb] = bank;
        addr[IndexLsb +: RamIndexBits] = index;
        return addr;
    endfunction

    task automatic busWrite(input busAddr_t addr, input busWord_t data);
        @(posedge mgt_rec_clk);
        busAddr <= addr;
        busWrData <= data;
        busWrEn <= 1'b1;
        @(posedge mgt_rec_clk);
        busWrEn <= 1'b0;
    endtask

    task automatic busRead(input busAddr_t addr, output busWord_t data);
        int latency;
        int expLatency;
        logic ack;
        logic [1:0] bank;
        bank = addr[BankMsb:BankLsb];
        // mapping rams need one extra stage
        expLatency = (bank == BankMapA || bank == BankMapB) ? 2 : 1;
        @(posedge mgt_rec_clk);
        busAddr <= addr;
        busRdEn <= 1'b1;
        @(posedge mgt_rec_clk);
        busRdEn <= 1'b0;
        latency = 0;
        ack = 1'b0;
        while (!ack && latency < 4) begin
            @(negedge mgt_rec_clk);
            latency = latency + 1;
            ack = (busRdAck === 1'b1);
        end
        if (!ack) begin
            $display("no read acknowledge within 4 cycles for address %h", addr);
            $display("TB FAILED");
            $fatal(1, "bus read hung");
        end
        checkWord("busRdAck latency", busWord_t'(latency), busWord_t'(expLatency));
        data = busRdData;
    endtask

    task automatic readCheck(input busAddr_t addr, input busWord_t exp, input string name);
        busWord_t data;
        busRead(addr, data);
        checkWord(name, data, exp);
    endtask

    task automatic setChannel(input int n, input busWord_t delay, input busWord_t width);
        busWrite(addrOf(BankRegs, eventCode_t'(2 * n)), delay);
        busWrite(addrOf(BankRegs, eventCode_t'(2 * n + 1)), width);
    endtask

    task automatic mapCode(input logic [1:0] bank, input eventCode_t code, input mapWord_t bits);
        busWrite(addrOf(bank, code), {16'd0, bits});
    endtask

    // returns just after the edge that samples the code
    task automatic sendEvent(input eventCode_t code, input logic isK);
        @(posedge mgt_rec_clk);
        mgtParData <= {8'h00, code};
        mgtCharIsK <= {1'b0, isK};
        @(posedge mgt_rec_clk);
        mgtParData <= IdleWord;
        mgtCharIsK <= 2'b01;
    endtask

    // bits valid after sample edge + 1
    // pulse from sample edge + delay + 2 on
    task automatic watchPulse(input triggerVec_t mask, input int delay, input int width,
                              input int cycles);
        logic active;
        for (int j = 0; j < cycles; j++) begin
            @(negedge mgt_rec_clk);
            active = (width != 0) && (j >= delay + 2) && (j <= delay + 1 + width);
            checkTriggers($sformatf("trigger cycle %0d", j), trigger,
                          polVec ^ (active ? mask : triggerVec_t'(0)));
        end
    endtask

    // fifo keeps the time of the cycle its bits are valid in
    task automatic pushEvent(input eventCode_t code);
        sendEvent(code, 1'b0);
        @(negedge mgt_rec_clk);
        expTimes.push_back(timeStamp + 64'd1);
        expCodes.push_back(code);
    endtask

    task automatic drainFifo(input int n);
        timeStamp_t t;
        eventCode_t c;
        for (int k = 0; k < n; k++) begin
            t = expTimes.pop_front();
            c = expCodes.pop_front();
            readCheck(addrOf(BankRegs, eventCode_t'(RegFifoTimeHi)), t[63:32], "fifo time hi");
            readCheck(addrOf(BankRegs, eventCode_t'(RegFifoTimeLo)), t[31:0], "fifo time lo");
            readCheck(addrOf(BankRegs, eventCode_t'(RegFifoCode)), {24'd0, c}, "fifo code");
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic registerReadback();
        busWord_t vals[10];
        @(negedge mgt_rec_clk);
        checkBit("busRdAck", busRdAck, 1'b0);
        checkBit("intrFifoNotEmpty", intrFifoNotEmpty, 1'b0);
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoStatus)), 32'h1, "fifo status");
        readCheck(addrOf(BankRegs, eventCode_t'(RegLatchHi)), 32'h0, "latch hi after reset");
        readCheck(addrOf(BankRegs, eventCode_t'(RegLatchLo)), 32'h0, "latch lo after reset");
        // delays, widths, polarity and control
        for (int i = 0; i < 10; i++) begin
            vals[i] = $random(seed);
            busWrite(addrOf(BankRegs, eventCode_t'(i)), vals[i]);
        end
        for (int i = 0; i < 10; i++) begin
            readCheck(addrOf(BankRegs, eventCode_t'(i)), vals[i], $sformatf("register %0d", i));
        end
        readCheck(addrOf(BankUnused, 8'h05), 32'h0, "bank 3 word");
        busWrite(addrOf(BankRegs, eventCode_t'(RegPolarity)), 32'h0);
        busWrite(addrOf(BankRegs, eventCode_t'(RegControl)), 32'h0);
        polVec = '0;
    endtask

    task automatic mapRamReadback();
        eventCode_t idx[8];
        busWord_t wa[8];
        busWord_t wb[8];
        busWord_t r;
        // one index per block of 32 keeps them distinct
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            idx[i] = {i[2:0], r[4:0]};
            wa[i] = $random(seed);
            wb[i] = $random(seed);
            busWrite(addrOf(BankMapA, idx[i]), wa[i]);
            busWrite(addrOf(BankMapB, idx[i]), wb[i]);
        end
        for (int i = 0; i < 8; i++) begin
            readCheck(addrOf(BankMapA, idx[i]), {16'd0, wa[i][15:0]}, "ram A word");
            readCheck(addrOf(BankMapB, idx[i]), {16'd0, wb[i][15:0]}, "ram B word");
        end
    endtask

    task automatic channelTiming();
        setChannel(0, 32'd3, 32'd2);
        mapCode(BankMapA, 8'h01, 16'h0001);
        sendEvent(8'h01, 1'b0);
        watchPulse(triggerVec_t'(1), 3, 2, 9);
        // inverted idle level
        busWrite(addrOf(BankRegs, eventCode_t'(RegPolarity)), 32'h1);
        polVec = triggerVec_t'(1);
        repeat (2) @(negedge mgt_rec_clk);
        checkTriggers("trigger idle inverted", trigger, polVec);
        sendEvent(8'h01, 1'b0);
        watchPulse(triggerVec_t'(1), 3, 2, 9);
        // K character fires nothing
        sendEvent(8'h01, 1'b1);
        watchPulse(triggerVec_t'(0), 3, 2, 9);
        busWrite(addrOf(BankRegs, eventCode_t'(RegPolarity)), 32'h0);
        polVec = '0;
        repeat (2) @(negedge mgt_rec_clk);
        // long pulse cut short by a width write
        setChannel(0, 32'd0, 32'd10);
        sendEvent(8'h01, 1'b0);
        watchPulse(triggerVec_t'(1), 0, 10, 4);
        busWrite(addrOf(BankRegs, 8'h01), 32'd10);
        repeat (6) begin
            @(negedge mgt_rec_clk);
            checkTriggers("trigger after clear", trigger, polVec);
        end
    endtask

    task automatic ramSelection();
        setChannel(1, 32'd0, 32'd1);
        setChannel(2, 32'd0, 32'd1);
        mapCode(BankMapA, 8'h22, 16'h0002);
        mapCode(BankMapB, 8'h22, 16'h0004);
        sendEvent(8'h22, 1'b0);
        watchPulse(triggerVec_t'(2), 0, 1, 5);
        busWrite(addrOf(BankRegs, eventCode_t'(RegControl)), 32'h1);
        sendEvent(8'h22, 1'b0);
        watchPulse(triggerVec_t'(4), 0, 1, 5);
        busWrite(addrOf(BankRegs, eventCode_t'(RegControl)), 32'h0);
    endtask

    task automatic timestampFifo();
        timeStamp_t expLatch;
        // latch on bit 14
        mapCode(BankMapA, 8'h40, 16'h4000);
        sendEvent(8'h40, 1'b0);
        @(negedge mgt_rec_clk);
        expLatch = timeStamp + 64'd1;
        repeat (3) @(negedge mgt_rec_clk);
        readCheck(addrOf(BankRegs, eventCode_t'(RegLatchHi)), expLatch[63:32], "latch hi");
        readCheck(addrOf(BankRegs, eventCode_t'(RegLatchLo)), expLatch[31:0], "latch lo");
        // three entries in order
        for (int i = 1; i <= 3; i++) begin
            mapCode(BankMapA, eventCode_t'(8'h30 + i), 16'h2000);
        end
        for (int i = 1; i <= 3; i++) begin
            pushEvent(eventCode_t'(8'h30 + i));
        end
        repeat (3) @(negedge mgt_rec_clk);
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoStatus)), 32'h0, "fifo status");
        drainFifo(3);
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoStatus)), 32'h1, "fifo status");
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoCode)), 32'h0, "empty fifo code");
        checkBit("intrFifoNotEmpty", intrFifoNotEmpty, 1'b0);
        // seventeenth push is dropped
        for (int i = 0; i < 17; i++) begin
            mapCode(BankMapA, eventCode_t'(8'h60 + i), 16'h2000);
        end
        for (int i = 0; i < 17; i++) begin
            pushEvent(eventCode_t'(8'h60 + i));
        end
        void'(expTimes.pop_back());
        void'(expCodes.pop_back());
        repeat (3) @(negedge mgt_rec_clk);
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoStatus)), 32'h2, "fifo status full");
        checkBit("intrFifoFull", intrFifoFull, 1'b1);
        checkBit("intrFifoNotEmpty", intrFifoNotEmpty, 1'b1);
        drainFifo(16);
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoStatus)), 32'h1, "fifo status");
        readCheck(addrOf(BankRegs, eventCode_t'(RegFifoCode)), 32'h0, "empty fifo code");
        checkBit("intrFifoFull", intrFifoFull, 1'b0);
    endtask

    initial begin
        bus_reset_n <= 1'b0;
        busAddr <= '0;
        busWrData <= '0;
        busWrEn <= 1'b0;
        busRdEn <= 1'b0;
        // idle link sends K characters
        mgtParData <= IdleWord;
        mgtCharIsK <= 2'b01;
        polVec = '0;
        repeat (4) @(posedge mgt_rec_clk);
        bus_reset_n <= 1'b1;
        registerReadback();
        mapRamReadback();
        channelTiming();
        ramSelection();
        timestampFifo();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: source/eventReceiverTop.sv
module eventReceiverTop import evrPkg::*; (
    input  logic        mgt_rec_clk,
    input  logic        bus_reset_n,
    input  busAddr_t    busAddr,
    input  busWord_t    busWrData,
    input  logic        busWrEn,
    input  logic        busRdEn,
    output busWord_t    busRdData,
    output logic        busRdAck,
    // low byte carries the event code, high byte unused here
    input  logic [15:0] mgtParData,
    input  logic [1:0]  mgtCharIsK,
    input  timeStamp_t  timeStamp,
    output triggerVec_t trigger,
    output logic        intrFifoNotEmpty,
    output logic        intrFifoFull
);

    // bus side of the mapping rams
    logic ramWrEnA;
    logic ramWrEnB;
    logic ramSelB;
    logic ramRdSelB;
    eventCode_t ramIndex;
    mapWord_t ramWrData;
    mapWord_t ramRdData;

    // lookup results
    eventBits_t events;
    eventCode_t eventCodeOut;

    // fifo and latch
    timeStamp_t latchTime;
    timeStamp_t fifoTime;
    eventCode_t fifoCode;
    logic fifoEmpty;
    logic fifoFull;
    logic fifoPop;

    // trigger channel settings
    busWord_t [NumChannels-1:0] chanDelay;
    busWord_t [NumChannels-1:0] chanWidth;
    triggerVec_t polarity;
    triggerVec_t chanClear;

    assign intrFifoFull = fifoFull;

    //////////////////////////////////////////////////
    // control registers and bus decode
    //////////////////////////////////////////////////
    evrRegisterBank u_evrRegisterBank (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n),
        .busAddr(busAddr),
        .busWrData(busWrData),
        .busWrEn(busWrEn),
        .busRdEn(busRdEn),
        .ramRdData(ramRdData),
        .latchTime(latchTime),
        .fifoTime(fifoTime),
        .fifoCode(fifoCode),
        .fifoEmpty(fifoEmpty),
        .fifoFull(fifoFull),
        .busRdData(busRdData),
        .busRdAck(busRdAck),
        .ramWrEnA(ramWrEnA),
        .ramWrEnB(ramWrEnB),
        .ramIndex(ramIndex),
        .ramWrData(ramWrData),
        .ramSelB(ramSelB),
        .ramRdSelB(ramRdSelB),
        .fifoPop(fifoPop),
        .chanDelay(chanDelay),
        .chanWidth(chanWidth),
        .polarity(polarity),
        .chanClear(chanClear)
    );

    // event code to event bits
    eventMappingRam u_eventMappingRam (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n),
        .ramWrEnA(ramWrEnA),
        .ramWrEnB(ramWrEnB),
        .ramIndex(ramIndex),
        .ramWrData(ramWrData),
        .ramSelB(ramSelB),
        .ramRdSelB(ramRdSelB),
        .eventCode(mgtParData[7:0]),
        .codeIsK(mgtCharIsK[0]),
        .ramRdData(ramRdData),
        .events(events),
        .eventCodeOut(eventCodeOut)
    );

    eventTimeFifo u_eventTimeFifo (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n),
        .timeStamp(timeStamp),
        .eventCode(eventCodeOut),
        .events(events),
        .pop(fifoPop),
        .latchTime(latchTime),
        .headTime(fifoTime),
        .headCode(fifoCode),
        .empty(fifoEmpty),
        .full(fifoFull),
        .notEmpty(intrFifoNotEmpty)
    );

    //////////////////////////////////////////////////
    // one pulse generator per low event bit
    //////////////////////////////////////////////////
    for (genvar n = 0; n < NumChannels; n++) begin : gChannel
        triggerChannel u_triggerChannel (
            .mgt_rec_clk(mgt_rec_clk),
            .bus_reset_n(bus_reset_n),
            .eventHit(events[n]),
            .delay(chanDelay[n]),
            .width(chanWidth[n]),
            .invert(polarity[n]),
            .clear(chanClear[n]),
            .trigger(trigger[n])
        );
    end

endmodule

// File: source/eventTimeFifo.sv
module eventTimeFifo import evrPkg::*; (
    input  logic       mgt_rec_clk,
    input  logic       bus_reset_n,
    input  timeStamp_t timeStamp,
    input  eventCode_t eventCode,
    input  eventBits_t events,
    input  logic       pop,
    output timeStamp_t latchTime,
    output timeStamp_t headTime,
    output eventCode_t headCode,
    output logic       empty,
    output logic       full,
    output logic       notEmpty
);

    localparam int Depth = 1 << FifoDepthBits;

    timeStamp_t timeMem [Depth];
    eventCode_t codeMem [Depth];
    logic [FifoDepthBits-1:0] wrPtr;
    logic [FifoDepthBits-1:0] rdPtr;
    // one extra bit to tell full from empty
    logic [FifoDepthBits:0] count;
    logic doPush;
    logic doPop;

    assign empty = (count == '0);
    // count tops out at Depth, so the msb alone means full
    assign full = count[FifoDepthBits];
    assign notEmpty = !empty;

    // push on full is dropped, pop on empty does nothing
    assign doPush = events[EvFifoBit] && !full;
    assign doPop = pop && !empty;

    assign headTime = timeMem[rdPtr];
    assign headCode = codeMem[rdPtr];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    always_ff @(posedge mgt_rec_clk) begin
        if (doPush) begin
            timeMem[wrPtr] <= timeStamp;
            codeMem[wrPtr] <= eventCode;
        end
    end

    // pointers, count and timestamp latch
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            latchTime <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + {{FifoDepthBits{1'b0}}, doPush} - {{FifoDepthBits{1'b0}}, doPop};
            if (events[EvLatchBit]) begin
                latchTime <= timeStamp;
            end
        end
    end

endmodule

// File: source/triggerChannel.sv
module triggerChannel import evrPkg::*; (
    input  logic     mgt_rec_clk,
    input  logic     bus_reset_n,
    input  logic     eventHit,
    input  busWord_t delay,
    input  busWord_t width,
    input  logic     invert,
    input  logic     clear,
    output logic     trigger
);

    typedef enum logic [1:0] {StIdle, StDelay, StPulse} chanState_t;

    chanState_t state;
    chanState_t nextState;
    // shared down-counter for delay and pulse length
    busWord_t count;
    busWord_t nextCount;

    always_comb begin
        nextState = state;
        nextCount = count;
        if (clear) begin
            nextState = StIdle;
            nextCount = '0;
        end else begin
            case (state)
                StIdle: begin
                    // zero width means no pulse at all
                    if (eventHit && (width != '0)) begin
                        if (delay == '0) begin
                            nextState = StPulse;
                            nextCount = width - 32'd1;
                        end else begin
                            nextState = StDelay;
                            nextCount = delay - 32'd1;
                        end
                    end
                end
                StDelay: begin
                    if (count == '0) begin
                        nextState = StPulse;
                        nextCount = width - 32'd1;
                    end else begin
                        nextCount = count - 32'd1;
                    end
                end
                StPulse: begin
                    if (count == '0) begin
                        nextState = StIdle;
                    end else begin
                        nextCount = count - 32'd1;
                    end
                end
                default: nextState = StIdle;
            endcase
        end
    end

    // output is raw pulse of the next cycle xor polarity
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            state <= StIdle;
            count <= '0;
            trigger <= 1'b0;
        end else begin
            state <= nextState;
            count <= nextCount;
            trigger <= (nextState == StPulse) ^ invert;
        end
    end

endmodule

// File: source/eventMappingRam.sv
module eventMappingRam import evrPkg::*; (
    input  logic       mgt_rec_clk,
    input  logic       bus_reset_n,
    input  logic       ramWrEnA,
    input  logic       ramWrEnB,
    input  eventCode_t ramIndex,
    input  mapWord_t   ramWrData,
    input  logic       ramSelB,
    input  logic       ramRdSelB,
    input  eventCode_t eventCode,
    input  logic       codeIsK,
    output mapWord_t   ramRdData,
    output eventBits_t events,
    output eventCode_t eventCodeOut
);

    mapWord_t memA [1 << RamIndexBits];
    mapWord_t memB [1 << RamIndexBits];

    // bus port registers
    mapWord_t busWordA;
    mapWord_t busWordB;
    logic busSelB;

    // lookup first stage
    mapWord_t lookWordA;
    mapWord_t lookWordB;
    eventCode_t codeReg;
    logic kReg;

    //////////////////////////////////////////////////
    // bus port, writes and registered reads
    //////////////////////////////////////////////////
    always_ff @(posedge mgt_rec_clk) begin
        if (ramWrEnA) begin
            memA[ramIndex] <= ramWrData;
        end
        if (ramWrEnB) begin
            memB[ramIndex] <= ramWrData;
        end
        busWordA <= memA[ramIndex];
        busWordB <= memB[ramIndex];
        // bank travels with the read
        busSelB <= ramRdSelB;
    end

    assign ramRdData = busSelB ? busWordB : busWordA;

    //////////////////////////////////////////////////
    // lookup port, code in at T, bits out after T+1
    //////////////////////////////////////////////////
    always_ff @(posedge mgt_rec_clk) begin
        lookWordA <= memA[eventCode];
        lookWordB <= memB[eventCode];
        codeReg <= eventCode;
    end

    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            // behave as a K character until the first code
            kReg <= 1'b1;
            events <= '0;
        end else begin
            kReg <= codeIsK;
            events <= kReg ? '0 : (ramSelB ? lookWordB : lookWordA);
        end
    end

    // code aligned with its bits for the fifo
    always_ff @(posedge mgt_rec_clk) begin
        eventCodeOut <= codeReg;
    end

endmodule

// File: source/evrRegisterBank.sv
module evrRegisterBank import evrPkg::*; (
    input  logic                       mgt_rec_clk,
    input  logic                       bus_reset_n,
    input  busAddr_t                   busAddr,
    input  busWord_t                   busWrData,
    input  logic                       busWrEn,
    input  logic                       busRdEn,
    input  mapWord_t                   ramRdData,
    input  timeStamp_t                 latchTime,
    input  timeStamp_t                 fifoTime,
    input  eventCode_t                 fifoCode,
    input  logic                       fifoEmpty,
    input  logic                       fifoFull,
    output busWord_t                   busRdData,
    output logic                       busRdAck,
    output logic                       ramWrEnA,
    output logic                       ramWrEnB,
    output eventCode_t                 ramIndex,
    output mapWord_t                   ramWrData,
    output logic                       ramSelB,
    output logic                       ramRdSelB,
    output logic                       fifoPop,
    output busWord_t [NumChannels-1:0] chanDelay,
    output busWord_t [NumChannels-1:0] chanWidth,
    output triggerVec_t                polarity,
    output triggerVec_t                chanClear
);

    logic [1:0] bank;
    logic isMapBank;
    logic regWrEn;
    regIndex_t regIndex;
    busWord_t polarityReg;
    busWord_t controlReg;
    busWord_t regRdData;
    // memory read waiting on the registered ram output
    logic memRdPend;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////
    assign bank = busAddr[BankMsb:BankLsb];
    assign regIndex = busAddr[IndexLsb +: $bits(regIndex_t)];
    assign isMapBank = (bank == BankMapA) || (bank == BankMapB);
    assign regWrEn = busWrEn && (bank == BankRegs);

    // mapping ram bus port
    assign ramIndex = busAddr[IndexLsb +: RamIndexBits];
    assign ramWrData = busWrData[$bits(mapWord_t)-1:0];
    assign ramWrEnA = busWrEn && (bank == BankMapA);
    assign ramWrEnB = busWrEn && (bank == BankMapB);
    assign ramRdSelB = (bank == BankMapB);

    assign ramSelB = controlReg[0];
    assign polarity = polarityReg[NumChannels-1:0];

    // head entry leaves at the same edge it is read
    assign fifoPop = busRdEn && (bank == BankRegs) && (regIndex == RegFifoCode) && !fifoEmpty;

    // channel clear on any write touching its settings
    always_comb begin
        for (int n = 0; n < NumChannels; n++) begin
            chanClear[n] = regWrEn && ((regIndex == regIndex_t'(RegDelay0 + 2 * n))
                || (regIndex == regIndex_t'(RegDelay0 + 2 * n + 1))
                || (regIndex == RegPolarity));
        end
    end

    //////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            chanDelay <= '0;
            chanWidth <= '0;
            polarityReg <= '0;
            controlReg <= '0;
        end else if (regWrEn) begin
            for (int n = 0; n < NumChannels; n++) begin
                if (regIndex == regIndex_t'(RegDelay0 + 2 * n)) begin
                    chanDelay[n] <= busWrData;
                end
                if (regIndex == regIndex_t'(RegDelay0 + 2 * n + 1)) begin
                    chanWidth[n] <= busWrData;
                end
            end
            if (regIndex == RegPolarity) begin
                polarityReg <= busWrData;
            end
            if (regIndex == RegControl) begin
                controlReg <= busWrData;
            end
        end
    end

    // register read mux
    always_comb begin
        regRdData = '0;
        for (int n = 0; n < NumChannels; n++) begin
            if (regIndex == regIndex_t'(RegDelay0 + 2 * n)) begin
                regRdData = chanDelay[n];
            end
            if (regIndex == regIndex_t'(RegDelay0 + 2 * n + 1)) begin
                regRdData = chanWidth[n];
            end
        end
        case (regIndex)
            RegPolarity: regRdData = polarityReg;
            RegControl: regRdData = controlReg;
            RegLatchHi: regRdData = latchTime[63:32];
            RegLatchLo: regRdData = latchTime[31:0];
            RegFifoStatus: regRdData = {30'd0, fifoFull, fifoEmpty};
            RegFifoTimeHi: regRdData = fifoTime[63:32];
            RegFifoTimeLo: regRdData = fifoTime[31:0];
            // empty fifo reads as zero
            RegFifoCode: regRdData = fifoEmpty ? '0 : {24'd0, fifoCode};
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // read path, 1 cycle for regs, 2 for rams
    //////////////////////////////////////////////////
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            memRdPend <= 1'b0;
            busRdAck <= 1'b0;
        end else begin
            memRdPend <= busRdEn && isMapBank;
            busRdAck <= (busRdEn && !isMapBank) || memRdPend;
        end
    end

    // data word, unused bank gives zero
    always_ff @(posedge mgt_rec_clk) begin
        if (memRdPend) begin
            busRdData <= {16'd0, ramRdData};
        end else if (busRdEn) begin
            busRdData <= (bank == BankRegs) ? regRdData : '0;
        end
    end

endmodule

// File: source/evrPkg.sv
package evrPkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // mapping ram depth is 2**RamIndexBits
    localparam int RamIndexBits = 8;
    localparam int NumChannels = 4;
    // fifo holds 2**FifoDepthBits entries
    localparam int FifoDepthBits = 4;

    // bus and link types
    typedef logic [31:0] busWord_t;
    typedef logic [31:0] busAddr_t;
    typedef logic [7:0] eventCode_t;
    typedef logic [15:0] eventBits_t;
    typedef logic [63:0] timeStamp_t;
    typedef logic [15:0] mapWord_t;
    typedef logic [3:0] regIndex_t;
    typedef logic [NumChannels-1:0] triggerVec_t;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // bank field sits at address bits 14..13
    localparam int BankLsb = 13;
    localparam int BankMsb = 14;
    localparam logic [1:0] BankRegs = 2'd0;
    localparam logic [1:0] BankMapA = 2'd1;
    localparam logic [1:0] BankMapB = 2'd2;
    // bank 3 reads as zero
    localparam logic [1:0] BankUnused = 2'd3;
    // word index starts above the byte select
    localparam int IndexLsb = 2;

    // register indices, channel n uses 2n for delay and 2n+1 for width
    localparam regIndex_t RegDelay0 = 4'd0;
    localparam regIndex_t RegPolarity = 4'd8;
    localparam regIndex_t RegControl = 4'd9;
    localparam regIndex_t RegLatchHi = 4'd10;
    localparam regIndex_t RegLatchLo = 4'd11;
    localparam regIndex_t RegFifoStatus = 4'd12;
    localparam regIndex_t RegFifoTimeHi = 4'd13;
    localparam regIndex_t RegFifoTimeLo = 4'd14;
    // read pops the fifo
    localparam regIndex_t RegFifoCode = 4'd15;

    // event bits with a fixed meaning, triggers use 0..NumChannels-1
    localparam int EvFifoBit = 13;
    localparam int EvLatchBit = 14;

endpackage
